// ==== fpu_data_pkg.sv ====
`default_nettype none

package fpu_data_pkg;

  // operand geometry
  parameter int DATA_W = 64;
  parameter int SNG_W  = 32;

  // two singles side by side, hi in the upper word
  typedef struct packed {
    logic [SNG_W-1:0] hi;
    logic [SNG_W-1:0] lo;
  } operand_t;

  // scalar compare outcome, exactly one set per scalar result
  typedef struct packed {
    logic lt;
    logic eq;
    logic gt;
    logic unord;
  } cmp_flags_t;

  // raised exception conditions
  typedef struct packed {
    logic invalid;
    logic denormal;
  } raise_t;

  // trap enables in fpcsr
  // two bits, invalid above denormal as in raise_t
  parameter int EXC_EN_LSB = 11;

  // codes reported on exc_code
  parameter logic [3:0] EXC_INVALID  = 4'd1;
  parameter logic [3:0] EXC_DENORMAL = 4'd2;

endpackage

`default_nettype wire

// ==== fpu_op_pkg.sv ====
`default_nettype none

package fpu_op_pkg;

  // issue opcodes handled by this cluster
  typedef enum logic [7:0] {
    OP_CMP_S   = 8'h30,
    OP_PCMP_LT = 8'h34,
    OP_SWAP    = 8'h48,
    OP_DUP_LO  = 8'h49,
    OP_MERGE   = 8'h4a
  } opcode_t;

  // which stage-2 lane takes the operation
  typedef enum logic [1:0] {
    LANE_NONE = 2'd0,
    LANE_CMP  = 2'd1,
    LANE_PERM = 2'd2
  } lane_t;

  // permute selections
  parameter logic [1:0] PERM_SWAP   = 2'd0;
  parameter logic [1:0] PERM_DUP_LO = 2'd1;
  parameter logic [1:0] PERM_MERGE  = 2'd2;

  typedef struct packed {
    lane_t      lane;
    logic       is_packed;
    logic [1:0] perm_mode;
  } fpu_ctrl_t;

endpackage

`default_nettype wire

// ==== fpu_issue_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// decoded operation from stage 1 to the stage-2 lanes
interface fpu_issue_if;

  logic                   valid;
  fpu_op_pkg::fpu_ctrl_t  ctrl;
  fpu_data_pkg::operand_t opnd_a;
  fpu_data_pkg::operand_t opnd_b;

  modport decode (
    output valid,
    output ctrl,
    output opnd_a,
    output opnd_b
  );

  // no ready, each lane claims its own ops by ctrl.lane
  modport lane (
    input valid,
    input ctrl,
    input opnd_a,
    input opnd_b
  );

endinterface

`default_nettype wire

// ==== operand_bypass.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_bypass #(
  parameter int NUM_FWD = 2
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  fpu_data_pkg::operand_t               issue_value,
  input  logic [1:0]                           fwd_now,
  input  logic [1:0]                           fwd_old,
  input  fpu_data_pkg::operand_t [NUM_FWD-1:0] fwd_bus,
  output fpu_data_pkg::operand_t               operand
);

  // bus values as they were one cycle back
  fpu_data_pkg::operand_t [NUM_FWD-1:0] bus_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      bus_q <= '0;
    end else begin
      bus_q <= fwd_bus;
    end
  end

  // current-cycle bus wins over the delayed copy
  always_comb begin
    operand = issue_value;
    if (fwd_now != 2'd0) begin
      operand = fwd_bus[fwd_now - 2'd1];
    end else if (fwd_old != 2'd0) begin
      operand = bus_q[fwd_old - 2'd1];
    end
  end

  // selects must name an existing bus
  a_fwd_range: assert property (
    @(posedge clk) disable iff (rst)
    (fwd_now <= NUM_FWD) && (fwd_old <= NUM_FWD)
  ) else $error("forwarding select beyond NUM_FWD");

endmodule

`default_nettype wire

// ==== fpu_op_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpu_op_decode (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue_valid,
  input  logic [7:0]             issue_op,
  input  fpu_data_pkg::operand_t opnd_a,
  input  fpu_data_pkg::operand_t opnd_b,
  fpu_issue_if.decode            iss
);

  fpu_op_pkg::fpu_ctrl_t ctrl_d;
  logic                  op_known;

  // opcodes accepted by this cluster
  assign op_known = issue_op inside {fpu_op_pkg::OP_CMP_S, fpu_op_pkg::OP_PCMP_LT,
                                     fpu_op_pkg::OP_SWAP, fpu_op_pkg::OP_DUP_LO,
                                     fpu_op_pkg::OP_MERGE};

  // opcode to lane control
  always_comb begin
    ctrl_d.lane      = fpu_op_pkg::LANE_NONE;
    ctrl_d.is_packed = 1'b0;
    ctrl_d.perm_mode = fpu_op_pkg::PERM_SWAP;
    case (fpu_op_pkg::opcode_t'(issue_op))
      fpu_op_pkg::OP_CMP_S: begin
        ctrl_d.lane = fpu_op_pkg::LANE_CMP;
      end
      fpu_op_pkg::OP_PCMP_LT: begin
        ctrl_d.lane      = fpu_op_pkg::LANE_CMP;
        ctrl_d.is_packed = 1'b1;
      end
      fpu_op_pkg::OP_SWAP: begin
        ctrl_d.lane      = fpu_op_pkg::LANE_PERM;
        ctrl_d.perm_mode = fpu_op_pkg::PERM_SWAP;
      end
      fpu_op_pkg::OP_DUP_LO: begin
        ctrl_d.lane      = fpu_op_pkg::LANE_PERM;
        ctrl_d.perm_mode = fpu_op_pkg::PERM_DUP_LO;
      end
      fpu_op_pkg::OP_MERGE: begin
        ctrl_d.lane      = fpu_op_pkg::LANE_PERM;
        ctrl_d.perm_mode = fpu_op_pkg::PERM_MERGE;
      end
      // unknown opcode stays on LANE_NONE and is dropped
      default: begin
        ctrl_d.lane = fpu_op_pkg::LANE_NONE;
      end
    endcase
  end

  // stage 1
  always_ff @(posedge clk) begin
    if (rst) begin
      iss.valid <= 1'b0;
    end else begin
      iss.valid <= issue_valid && op_known;
    end
    iss.ctrl   <= ctrl_d;
    iss.opnd_a <= opnd_a;
    iss.opnd_b <= opnd_b;
  end

  // every known opcode decodes to a lane
  a_lane_named: assert property (
    @(posedge clk) disable iff (rst)
    iss.valid |-> (iss.ctrl.lane != fpu_op_pkg::LANE_NONE)
  ) else $error("valid operation without a lane");

endmodule

`default_nettype wire

// ==== fp_compare.sv ====
`timescale 1ns/1ns
`default_nettype none

module fp_compare (
  input  logic                     clk,
  input  logic                     rst,
  fpu_issue_if.lane                iss,
  output logic                     cmp_valid,
  output fpu_data_pkg::operand_t   cmp_data,
  output fpu_data_pkg::cmp_flags_t cmp_flags,
  output fpu_data_pkg::raise_t     cmp_raise
);

  typedef logic [fpu_data_pkg::SNG_W-1:0] sng_t;

  // all-ones exponent, nonzero fraction
  function automatic logic is_nan(input sng_t x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic is_denorm(input sng_t x);
    return (x[30:23] == 8'h00) && (x[22:0] != 23'd0);
  endfunction

  // ordered less-than, NaN screened by the caller
  function automatic logic ord_lt(input sng_t a, input sng_t b);
    logic lt;
    if ((a[30:0] == 31'd0) && (b[30:0] == 31'd0)) begin
      // +0 and -0 are equal
      lt = 1'b0;
    end else if (a[31] != b[31]) begin
      lt = a[31];
    end else if (a[31]) begin
      lt = a[30:0] > b[30:0];
    end else begin
      lt = a[30:0] < b[30:0];
    end
    return lt;
  endfunction

  logic                     nan_lo;
  logic                     nan_hi;
  logic                     den_lo;
  logic                     den_hi;
  logic                     lt_lo;
  logic                     lt_hi;
  logic                     gt_lo;
  fpu_data_pkg::operand_t   data_d;
  fpu_data_pkg::cmp_flags_t flags_d;
  fpu_data_pkg::raise_t     raise_d;

  assign nan_lo = is_nan(iss.opnd_a.lo) || is_nan(iss.opnd_b.lo);
  assign nan_hi = is_nan(iss.opnd_a.hi) || is_nan(iss.opnd_b.hi);
  assign den_lo = is_denorm(iss.opnd_a.lo) || is_denorm(iss.opnd_b.lo);
  assign den_hi = is_denorm(iss.opnd_a.hi) || is_denorm(iss.opnd_b.hi);
  assign lt_lo  = !nan_lo && ord_lt(iss.opnd_a.lo, iss.opnd_b.lo);
  assign lt_hi  = !nan_hi && ord_lt(iss.opnd_a.hi, iss.opnd_b.hi);
  assign gt_lo  = !nan_lo && ord_lt(iss.opnd_b.lo, iss.opnd_a.lo);

  always_comb begin
    if (iss.ctrl.is_packed) begin
      // per-half less-than mask
      data_d.hi        = {fpu_data_pkg::SNG_W{lt_hi}};
      data_d.lo        = {fpu_data_pkg::SNG_W{lt_lo}};
      flags_d          = '0;
      raise_d.invalid  = nan_hi || nan_lo;
      raise_d.denormal = den_hi || den_lo;
    end else begin
      // scalar on the low halves, result only in the flags
      data_d           = {fpu_data_pkg::DATA_W{1'b0}};
      flags_d.lt       = lt_lo;
      flags_d.gt       = gt_lo;
      flags_d.eq       = !nan_lo && !lt_lo && !gt_lo;
      flags_d.unord    = nan_lo;
      raise_d.invalid  = nan_lo;
      raise_d.denormal = den_lo;
    end
  end

  // stage 2
  always_ff @(posedge clk) begin
    if (rst) begin
      cmp_valid <= 1'b0;
    end else begin
      cmp_valid <= iss.valid && (iss.ctrl.lane == fpu_op_pkg::LANE_CMP);
    end
    cmp_data  <= data_d;
    cmp_flags <= flags_d;
    cmp_raise <= raise_d;
  end

endmodule

`default_nettype wire

// ==== fp_permute.sv ====
`timescale 1ns/1ns
`default_nettype none

module fp_permute (
  input  logic                   clk,
  input  logic                   rst,
  fpu_issue_if.lane              iss,
  output logic                   perm_valid,
  output fpu_data_pkg::operand_t perm_data
);

  fpu_data_pkg::operand_t data_d;

  // rearrange single-precision halves
  always_comb begin
    case (iss.ctrl.perm_mode)
      fpu_op_pkg::PERM_SWAP: begin
        data_d.hi = iss.opnd_a.lo;
        data_d.lo = iss.opnd_a.hi;
      end
      fpu_op_pkg::PERM_DUP_LO: begin
        data_d.hi = iss.opnd_a.lo;
        data_d.lo = iss.opnd_a.lo;
      end
      // merge, hi of a over lo of b
      default: begin
        data_d.hi = iss.opnd_a.hi;
        data_d.lo = iss.opnd_b.lo;
      end
    endcase
  end

  // stage 2
  always_ff @(posedge clk) begin
    if (rst) begin
      perm_valid <= 1'b0;
    end else begin
      perm_valid <= iss.valid && (iss.ctrl.lane == fpu_op_pkg::LANE_PERM);
    end
    perm_data <= data_d;
  end

endmodule

`default_nettype wire

// ==== fpu_writeback.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpu_writeback (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [31:0]              fpcsr,
  input  logic                     cmp_valid,
  input  fpu_data_pkg::operand_t   cmp_data,
  input  fpu_data_pkg::cmp_flags_t cmp_flags,
  input  fpu_data_pkg::raise_t     cmp_raise,
  input  logic                     perm_valid,
  input  fpu_data_pkg::operand_t   perm_data,
  output logic                     result_valid,
  output fpu_data_pkg::operand_t   result_data,
  output fpu_data_pkg::cmp_flags_t result_flags,
  output logic                     exc_valid,
  output logic [3:0]               exc_code
);

  fpu_data_pkg::raise_t raise_en;

  // raised and trap-enabled
  always_comb begin
    raise_en.invalid  = cmp_raise.invalid && fpcsr[fpu_data_pkg::EXC_EN_LSB + 1];
    raise_en.denormal = cmp_raise.denormal && fpcsr[fpu_data_pkg::EXC_EN_LSB];
  end

  // stage 3
  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      exc_valid    <= 1'b0;
    end else begin
      result_valid <= cmp_valid || perm_valid;
      exc_valid    <= cmp_valid && (raise_en.invalid || raise_en.denormal);
    end
    if (cmp_valid) begin
      result_data  <= cmp_data;
      result_flags <= cmp_flags;
    end else begin
      // permute carries no flags
      result_data  <= perm_data;
      result_flags <= '0;
    end
    // invalid takes priority
    exc_code <= raise_en.invalid ? fpu_data_pkg::EXC_INVALID : fpu_data_pkg::EXC_DENORMAL;
  end

  // decode hands each op to one lane only
  a_one_lane: assert property (
    @(posedge clk) disable iff (rst)
    !(cmp_valid && perm_valid)
  ) else $error("compare and permute results in the same cycle");

endmodule

`default_nettype wire

// ==== fpu_cluster.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpu_cluster #(
  parameter int NUM_FWD = 2
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [31:0]              fpcsr,
  input  logic                     issue_valid,
  input  logic [7:0]               issue_op,
  input  fpu_data_pkg::operand_t   issue_a,
  input  fpu_data_pkg::operand_t   issue_b,
  input  logic [1:0]               fwd_now_a,
  input  logic [1:0]               fwd_old_a,
  input  logic [1:0]               fwd_now_b,
  input  logic [1:0]               fwd_old_b,
  input  fpu_data_pkg::operand_t   fwd_bus0,
  input  fpu_data_pkg::operand_t   fwd_bus1,
  output logic                     result_valid,
  output fpu_data_pkg::operand_t   result_data,
  output fpu_data_pkg::cmp_flags_t result_flags,
  output logic                     exc_valid,
  output logic [3:0]               exc_code
);

  fpu_data_pkg::operand_t [NUM_FWD-1:0] fwd_bus;
  fpu_data_pkg::operand_t               opnd_a;
  fpu_data_pkg::operand_t               opnd_b;
  logic                                 cmp_valid;
  fpu_data_pkg::operand_t               cmp_data;
  fpu_data_pkg::cmp_flags_t             cmp_flags;
  fpu_data_pkg::raise_t                 cmp_raise;
  logic                                 perm_valid;
  fpu_data_pkg::operand_t               perm_data;

  // bus 0 in the low slot
  assign fwd_bus = {fwd_bus1, fwd_bus0};

  fpu_issue_if iss ();

  operand_bypass #(.NUM_FWD(NUM_FWD)) u_bypass_a (
    .clk         (clk),
    .rst         (rst),
    .issue_value (issue_a),
    .fwd_now     (fwd_now_a),
    .fwd_old     (fwd_old_a),
    .fwd_bus     (fwd_bus),
    .operand     (opnd_a)
  );

  operand_bypass #(.NUM_FWD(NUM_FWD)) u_bypass_b (
    .clk         (clk),
    .rst         (rst),
    .issue_value (issue_b),
    .fwd_now     (fwd_now_b),
    .fwd_old     (fwd_old_b),
    .fwd_bus     (fwd_bus),
    .operand     (opnd_b)
  );

  fpu_op_decode u_decode (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .opnd_a      (opnd_a),
    .opnd_b      (opnd_b),
    .iss         (iss)
  );

  fp_compare u_compare (
    .clk       (clk),
    .rst       (rst),
    .iss       (iss),
    .cmp_valid (cmp_valid),
    .cmp_data  (cmp_data),
    .cmp_flags (cmp_flags),
    .cmp_raise (cmp_raise)
  );

  fp_permute u_permute (
    .clk        (clk),
    .rst        (rst),
    .iss        (iss),
    .perm_valid (perm_valid),
    .perm_data  (perm_data)
  );

  fpu_writeback u_writeback (
    .clk          (clk),
    .rst          (rst),
    .fpcsr        (fpcsr),
    .cmp_valid    (cmp_valid),
    .cmp_data     (cmp_data),
    .cmp_flags    (cmp_flags),
    .cmp_raise    (cmp_raise),
    .perm_valid   (perm_valid),
    .perm_data    (perm_data),
    .result_valid (result_valid),
    .result_data  (result_data),
    .result_flags (result_flags),
    .exc_valid    (exc_valid),
    .exc_code     (exc_code)
  );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held for four rising edges, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb_fpu_cluster.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_fpu_cluster;

  typedef struct {
    int                       due;
    fpu_data_pkg::operand_t   data;
    fpu_data_pkg::cmp_flags_t flags;
    logic                     exc_v;
    logic [3:0]               code;
  } exp_t;

  logic                     clk;
  logic                     rst;
  logic [31:0]              fpcsr;
  logic                     issue_valid;
  logic [7:0]               issue_op;
  fpu_data_pkg::operand_t   issue_a;
  fpu_data_pkg::operand_t   issue_b;
  logic [1:0]               fwd_now_a;
  logic [1:0]               fwd_old_a;
  logic [1:0]               fwd_now_b;
  logic [1:0]               fwd_old_b;
  fpu_data_pkg::operand_t   fwd_bus0;
  fpu_data_pkg::operand_t   fwd_bus1;
  logic                     result_valid;
  fpu_data_pkg::operand_t   result_data;
  fpu_data_pkg::cmp_flags_t result_flags;
  logic                     exc_valid;
  logic [3:0]               exc_code;

  // model copies of the buses, this cycle and one back
  fpu_data_pkg::operand_t bus_cur [2];
  fpu_data_pkg::operand_t bus_prev [2];
  exp_t                   pending[$];
  int                     cycle;
  int                     errors;
  int                     checks;
  int                     tests;

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  fpu_cluster #(.NUM_FWD(2)) uut (
    .clk          (clk),
    .rst          (rst),
    .fpcsr        (fpcsr),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_a      (issue_a),
    .issue_b      (issue_b),
    .fwd_now_a    (fwd_now_a),
    .fwd_old_a    (fwd_old_a),
    .fwd_now_b    (fwd_now_b),
    .fwd_old_b    (fwd_old_b),
    .fwd_bus0     (fwd_bus0),
    .fwd_bus1     (fwd_bus1),
    .result_valid (result_valid),
    .result_data  (result_data),
    .result_flags (result_flags),
    .exc_valid    (exc_valid),
    .exc_code     (exc_code)
  );

  function automatic logic nan_s(input logic [31:0] x);
    return (&x[30:23]) && (|x[22:0]);
  endfunction

  function automatic logic subnormal_s(input logic [31:0] x);
    return (~|x[30:23]) && (|x[22:0]);
  endfunction

  // sign-magnitude to a signed key, both zeros map to 0
  function automatic logic signed [32:0] order_key(input logic [31:0] x);
    logic signed [32:0] mag;
    mag = {2'b00, x[30:0]};
    return x[31] ? -mag : mag;
  endfunction

  // special values come up often
  function automatic logic [31:0] rand_single();
    logic [31:0] r;
    logic [31:0] v;
    r = $urandom;
    case ($urandom_range(0, 7))
      0: v = {r[31], 8'hff, r[22:1], 1'b1};
      1: v = {r[31], 31'd0};
      2: v = {r[31], 8'h00, r[22:1], 1'b1};
      3: v = {r[31], 8'hff, 23'd0};
      // +-2.0 or +-4.0, so equal pairs happen
      4: v = {r[31], 7'h40, r[0], 23'd0};
      default: v = r;
    endcase
    return v;
  endfunction

  function automatic fpu_data_pkg::operand_t rand_operand();
    fpu_data_pkg::operand_t v;
    v.hi = rand_single();
    v.lo = rand_single();
    return v;
  endfunction

  function automatic logic known_op(input logic [7:0] op);
    case (op)
      fpu_op_pkg::OP_CMP_S, fpu_op_pkg::OP_PCMP_LT, fpu_op_pkg::OP_SWAP,
      fpu_op_pkg::OP_DUP_LO, fpu_op_pkg::OP_MERGE: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [7:0] rand_valid_op();
    case ($urandom_range(0, 4))
      0: return fpu_op_pkg::OP_CMP_S;
      1: return fpu_op_pkg::OP_PCMP_LT;
      2: return fpu_op_pkg::OP_SWAP;
      3: return fpu_op_pkg::OP_DUP_LO;
      default: return fpu_op_pkg::OP_MERGE;
    endcase
  endfunction

  // current bus first, then last cycle's copy, then the issue value
  function automatic fpu_data_pkg::operand_t forward(input fpu_data_pkg::operand_t v,
                                                     input logic [1:0] now,
                                                     input logic [1:0] old);
    fpu_data_pkg::operand_t sel;
    if (now == 2'd1) sel = bus_cur[0];
    else if (now == 2'd2) sel = bus_cur[1];
    else if (old == 2'd1) sel = bus_prev[0];
    else if (old == 2'd2) sel = bus_prev[1];
    else sel = v;
    return sel;
  endfunction

  function automatic exp_t predict(input logic [7:0] op, input fpu_data_pkg::operand_t a,
                                   input fpu_data_pkg::operand_t b, input logic [31:0] csr);
    exp_t e;
    logic nan_l;
    logic nan_h;
    logic inv;
    logic den;
    logic inv_on;
    logic den_on;
    e.due = 0;
    e.data = '0;
    e.flags = '0;
    inv = 1'b0;
    den = 1'b0;
    nan_l = nan_s(a.lo) || nan_s(b.lo);
    nan_h = nan_s(a.hi) || nan_s(b.hi);
    case (op)
      fpu_op_pkg::OP_CMP_S: begin
        if (nan_l) e.flags.unord = 1'b1;
        else if (order_key(a.lo) < order_key(b.lo)) e.flags.lt = 1'b1;
        else if (order_key(a.lo) > order_key(b.lo)) e.flags.gt = 1'b1;
        else e.flags.eq = 1'b1;
        inv = nan_l;
        den = subnormal_s(a.lo) || subnormal_s(b.lo);
      end
      fpu_op_pkg::OP_PCMP_LT: begin
        e.data.lo = {32{!nan_l && (order_key(a.lo) < order_key(b.lo))}};
        e.data.hi = {32{!nan_h && (order_key(a.hi) < order_key(b.hi))}};
        inv = nan_l || nan_h;
        den = subnormal_s(a.lo) || subnormal_s(b.lo) || subnormal_s(a.hi) || subnormal_s(b.hi);
      end
      fpu_op_pkg::OP_SWAP: e.data = {a.lo, a.hi};
      fpu_op_pkg::OP_DUP_LO: e.data = {a.lo, a.lo};
      fpu_op_pkg::OP_MERGE: e.data = {a.hi, b.lo};
      default: e.data = '0;
    endcase
    // trap enables, invalid before denormal
    inv_on = inv && csr[fpu_data_pkg::EXC_EN_LSB + 1];
    den_on = den && csr[fpu_data_pkg::EXC_EN_LSB];
    e.exc_v = inv_on || den_on;
    e.code = inv_on ? fpu_data_pkg::EXC_INVALID : fpu_data_pkg::EXC_DENORMAL;
    return e;
  endfunction

  task automatic report_value(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic check_outputs();
    exp_t e;
    if (result_valid) begin
      checks++;
      assert (pending.size() != 0) else begin
        errors++;
        $display("a result appeared at %0t with no operation outstanding", $time);
      end
      if (pending.size() != 0) begin
        e = pending.pop_front();
        assert (cycle == e.due)
          else report_value($sformatf("result in cycle %0d, expected %0d", cycle, e.due));
        assert (result_data == e.data)
          else report_value($sformatf("data %h, expected %h", result_data, e.data));
        assert (result_flags == e.flags)
          else report_value($sformatf("flags %b, expected %b", result_flags, e.flags));
        assert (exc_valid == e.exc_v)
          else report_value($sformatf("exc_valid %b, expected %b", exc_valid, e.exc_v));
        assert (!(e.exc_v && exc_valid) || (exc_code == e.code))
          else report_value($sformatf("exc_code %0d, expected %0d", exc_code, e.code));
      end
    end else begin
      assert (!exc_valid) else begin
        errors++;
        $display("exc_valid was high at %0t without a result", $time);
      end
      if (pending.size() != 0) begin
        assert (pending[0].due > cycle) else begin
          errors++;
          $display("the result due in cycle %0d never appeared", pending[0].due);
          void'(pending.pop_front());
        end
      end
    end
  endtask

  // one falling edge: check, then drive idle inputs and fresh bus values
  task automatic tick();
    @(negedge clk);
    cycle++;
    check_outputs();
    bus_prev = bus_cur;
    bus_cur[0] = rand_operand();
    bus_cur[1] = rand_operand();
    fwd_bus0 = bus_cur[0];
    fwd_bus1 = bus_cur[1];
    issue_valid = 1'b0;
    issue_a = rand_operand();
    issue_b = rand_operand();
    fwd_now_a = 2'd0;
    fwd_old_a = 2'd0;
    fwd_now_b = 2'd0;
    fwd_old_b = 2'd0;
  endtask

  task automatic issue(input logic [7:0] op, input fpu_data_pkg::operand_t a,
                       input fpu_data_pkg::operand_t b, input logic [1:0] na,
                       input logic [1:0] oa, input logic [1:0] nb, input logic [1:0] ob);
    exp_t e;
    tick();
    issue_valid = 1'b1;
    issue_op = op;
    issue_a = a;
    issue_b = b;
    fwd_now_a = na;
    fwd_old_a = oa;
    fwd_now_b = nb;
    fwd_old_b = ob;
    e = predict(op, forward(a, na, oa), forward(b, nb, ob), fpcsr);
    e.due = cycle + 3;
    if (known_op(op)) pending.push_back(e);
  endtask

  task automatic issue_plain(input logic [7:0] op);
    issue(op, rand_operand(), rand_operand(), 2'd0, 2'd0, 2'd0, 2'd0);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((pending.size() != 0) && (waited < 40)) begin
      tick();
      waited++;
    end
    if (pending.size() != 0) begin
      errors++;
      $display("timed out with %0d results still outstanding", pending.size());
      pending.delete();
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - err_start);
  endtask

  initial begin
    int   err_start;
    int   waited;
    int   start;
    logic seen;
    logic [7:0] op;
    void'($urandom(32'h41b2));
    fpcsr = '0;
    issue_valid = 1'b0;
    issue_op = '0;
    issue_a = '0;
    issue_b = '0;
    fwd_now_a = 2'd0;
    fwd_old_a = 2'd0;
    fwd_now_b = 2'd0;
    fwd_old_b = 2'd0;
    fwd_bus0 = '0;
    fwd_bus1 = '0;
    bus_cur[0] = '0;
    bus_cur[1] = '0;
    bus_prev = bus_cur;
    cycle = 0;
    errors = 0;
    checks = 0;
    tests = 0;

    waited = 0;
    while (rst && (waited < 20)) begin
      @(negedge clk);
      waited++;
    end
    if (rst) begin
      errors++;
      $display("reset was never released");
    end

    // quiet after reset, then one op and its latency
    err_start = errors;
    for (int i = 0; i < 10; i++) tick();
    issue_plain(fpu_op_pkg::OP_SWAP);
    start = cycle;
    seen = 1'b0;
    waited = 0;
    while (!seen && (waited < 10)) begin
      tick();
      waited++;
      seen = result_valid;
    end
    assert (seen) else begin
      errors++;
      $display("no result appeared for the single issued operation");
    end
    assert (!seen || (cycle - start == 3))
      else report_value($sformatf("latency %0d cycles, expected 3", cycle - start));
    drain();
    finish_test("reset and latency", err_start);

    err_start = errors;
    issue(fpu_op_pkg::OP_CMP_S, 64'h0000_0000_8000_0000, '0, 2'd0, 2'd0, 2'd0, 2'd0);
    issue(fpu_op_pkg::OP_CMP_S, 64'h0000_0000_7fc0_0000, '0, 2'd0, 2'd0, 2'd0, 2'd0);
    for (int i = 0; i < 200; i++) begin
      issue_plain(($urandom_range(0, 1) == 0) ? fpu_op_pkg::OP_CMP_S : fpu_op_pkg::OP_PCMP_LT);
    end
    drain();
    finish_test("compare", err_start);

    err_start = errors;
    for (int i = 0; i < 60; i++) begin
      issue_plain(8'(fpu_op_pkg::OP_SWAP + $urandom_range(0, 2)));
    end
    drain();
    finish_test("permute back to back", err_start);

    err_start = errors;
    for (int i = 0; i < 150; i++) begin
      issue(rand_valid_op(), rand_operand(), rand_operand(), 2'($urandom_range(0, 2)),
            2'($urandom_range(0, 2)), 2'($urandom_range(0, 2)), 2'($urandom_range(0, 2)));
    end
    drain();
    finish_test("forwarding", err_start);

    // trap enables change only while nothing is in flight
    err_start = errors;
    for (int batch = 0; batch < 20; batch++) begin
      fpcsr = $urandom;
      if (batch == 0) fpcsr[fpu_data_pkg::EXC_EN_LSB +: 2] = 2'b00;
      for (int i = 0; i < 12; i++) begin
        issue_plain(($urandom_range(0, 1) == 0) ? fpu_op_pkg::OP_CMP_S : fpu_op_pkg::OP_PCMP_LT);
      end
      drain();
    end
    fpcsr = '0;
    finish_test("exceptions", err_start);

    err_start = errors;
    for (int i = 0; i < 100; i++) begin
      op = 8'($urandom);
      if (known_op(op)) op = op ^ 8'h80;
      if ($urandom_range(0, 1) == 0) op = rand_valid_op();
      issue_plain(op);
    end
    drain();
    finish_test("unknown opcodes", err_start);

    $display("%0d tests, %0d results checked, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
fpu_data_pkg.sv
fpu_op_pkg.sv
fpu_issue_if.sv
operand_bypass.sv
fpu_op_decode.sv
fp_compare.sv
fp_permute.sv
fpu_writeback.sv
fpu_cluster.sv
tb_clock.sv
tb_fpu_cluster.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fpu_cluster -f verilog.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q -x "Testbench passed" sim.log; then
  echo "simulation ok"
  exit 0
else
  echo "simulation reported errors"
  exit 1
fi
